// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing -Wno-fatal -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = fetchTb
FILELIST  = fetch.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== fetch.f ====
source/fetchPkg.sv
source/pcGen.sv
source/instMem.sv
source/instCache.sv
source/hazardDetect.sv
source/fetchCtrl.sv
source/fetch.sv
verification/fetchTb.sv

// ==== source/fetch.sv ====
// fetch stage top level, connects PC, cache, instruction memory, hazard unit and control
`timescale 1ns/10ps
`default_nettype none

module fetch #(
   parameter int cacheLines  = 16,
   parameter int missLatency = 4,
   parameter int memWords    = 256
) (
   input  wire                           clk,
   input  wire                           rstN,
   input  wire [fetchPkg::dataWidth-1:0] newPC,
   input  wire                           redirect,
   input  wire                           createDump,
   input  wire fetchPkg::stageInfo_t     stageEx,
   input  wire fetchPkg::stageInfo_t     stageMem,
   input  wire fetchPkg::stageInfo_t     stageWb,
   input  wire                           progWrEn,
   input  wire [fetchPkg::dataWidth-2:0] progAddr,
   input  wire [fetchPkg::dataWidth-1:0] progData,
   output fetchPkg::fetchOut_t           fetchOut,
   output fetchPkg::fwdCtrl_t            fwd,
   output logic                          err
);
   import fetchPkg::*;

   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] incPC;
   logic                 pcWrap;
   logic                 pcWrEn;
   logic                 pcSel;
   logic                 bubble;
   logic                 cacheCancel;
   logic                 hit;
   logic                 misaligned;
   logic [dataWidth-1:0] cacheInst;
   logic                 memRdEn;
   logic [dataWidth-2:0] memRdAddr;
   logic [dataWidth-1:0] memRdData;
   logic                 loadUse;
   logic                 fetchedHalt;

   pcGen pcGenInst (
      .clk(clk), .rstN(rstN), .pcWrEn(pcWrEn), .pcSel(pcSel), .newPC(newPC),
      .pc(pc), .incPC(incPC), .pcWrap(pcWrap)
   );

   instCache #(.cacheLines(cacheLines), .missLatency(missLatency)) cacheInst0 (
      .clk(clk), .rstN(rstN), .pc(pc), .cacheCancel(cacheCancel), .memRdData(memRdData),
      .hit(hit), .cacheInst(cacheInst), .misaligned(misaligned),
      .memRdEn(memRdEn), .memRdAddr(memRdAddr)
   );

   instMem #(.memWords(memWords)) memInst (
      .clk(clk), .memRdEn(memRdEn), .memRdAddr(memRdAddr),
      .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
      .memRdData(memRdData)
   );

   hazardDetect hazardInst (
      .clk(clk), .rstN(rstN), .cacheInst(cacheInst), .incPC(incPC), .bubble(bubble),
      .stageEx(stageEx), .stageMem(stageMem), .stageWb(stageWb),
      .fetchOut(fetchOut), .fwd(fwd), .loadUse(loadUse), .fetchedHalt(fetchedHalt)
   );

   fetchCtrl ctrlInst (
      .clk(clk), .rstN(rstN), .redirect(redirect), .createDump(createDump),
      .hit(hit), .misaligned(misaligned), .pcWrap(pcWrap), .loadUse(loadUse),
      .fetchedHalt(fetchedHalt), .pcWrEn(pcWrEn), .pcSel(pcSel), .bubble(bubble),
      .cacheCancel(cacheCancel), .err(err)
   );

endmodule

`default_nettype wire

// ==== source/fetchCtrl.sv ====
// fetch control FSM for PC enable, bubbles, miss cancel, halt and sticky error
`timescale 1ns/10ps
`default_nettype none

module fetchCtrl (
   input  wire  clk,
   input  wire  rstN,
   input  wire  redirect,
   input  wire  createDump,
   input  wire  hit,
   input  wire  misaligned,
   input  wire  pcWrap,
   input  wire  loadUse,
   input  wire  fetchedHalt,
   output logic pcWrEn,
   output logic pcSel,
   output logic bubble,
   output logic cacheCancel,
   output logic err
);
   import fetchPkg::*;

   fetchState_t state;
   fetchState_t stateNext;
   logic        errSet;

   // halt beats redirect, redirect beats load-use, load-use beats miss
   always_comb begin
      pcWrEn = 1'b0;
      pcSel = 1'b0;
      bubble = 1'b1;
      cacheCancel = 1'b0;
      errSet = 1'b0;
      stateNext = state;
      if (state == stHalt) begin
         cacheCancel = 1'b1;
      end else if (createDump || fetchedHalt) begin
         cacheCancel = 1'b1;
         stateNext = stHalt;
      end else if (redirect) begin
         pcWrEn = 1'b1;
         pcSel = 1'b1;
         cacheCancel = 1'b1;
         stateNext = stRun;
      end else if (loadUse) begin
         // register holds its instruction, a pending fill keeps counting
         bubble = 1'b0;
         stateNext = hit ? stRun : stMiss;
      end else if (!hit) begin
         stateNext = stMiss;
      end else begin
         pcWrEn = 1'b1;
         bubble = 1'b0;
         errSet = misaligned || pcWrap;
         stateNext = errSet ? stHalt : stRun;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stRun;
         err <= 1'b0;
      end else begin
         state <= stateNext;
         err <= err || errSet;
      end
   end

endmodule

`default_nettype wire

// ==== source/fetchPkg.sv ====
// fetch stage widths, instruction encodings, opcode and state enums, stage and forwarding structs
`default_nettype none

package fetchPkg;

   localparam int dataWidth = 16;
   localparam int regAddrWidth = 3;

   localparam logic [dataWidth-1:0] nopInst = 16'h0800;
   localparam logic [dataWidth-1:0] haltInst = 16'h0000;

   // instruction bits 15:11
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opImm0 = 5'b01000,
      opImm1 = 5'b01001,
      opImm2 = 5'b01010,
      opImm3 = 5'b01011,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opAlu1 = 5'b11010,
      opAlu0 = 5'b11011,
      opAlu2 = 5'b11100,
      opAlu3 = 5'b11101
   } opcode_t;

   typedef enum logic [1:0] {stRun, stMiss, stHalt} fetchState_t;

   typedef enum logic [1:0] {fwdNone, fwdEx, fwdMem, fwdWb} fwdSel_t;

   // status of one later pipeline stage
   typedef struct packed {
      logic                    regWrt;
      logic [regAddrWidth-1:0] wrtReg;
      logic                    isLoad;
   } stageInfo_t;

   typedef struct packed {
      fwdSel_t srcA;
      fwdSel_t srcB;
   } fwdCtrl_t;

   typedef struct packed {
      logic [dataWidth-1:0] instruction;
      logic [dataWidth-1:0] incPC;
      logic                 instrValid;
   } fetchOut_t;

   // Rs sits in bits 10:8, read by all but halt and nop
   function automatic logic readsRs(opcode_t op);
      return !(op inside {opHalt, opNop});
   endfunction

   // Rt sits in bits 7:5, read by the store and the register-register classes
   function automatic logic readsRt(opcode_t op);
      return op inside {opSt, opAlu0, opAlu1, opAlu2, opAlu3};
   endfunction

endpackage

`default_nettype wire

// ==== source/hazardDetect.sv ====
// fetch/decode register with bubble insertion, load-use stall and forwarding selects
`timescale 1ns/10ps
`default_nettype none

module hazardDetect (
   input  wire                            clk,
   input  wire                            rstN,
   input  wire [fetchPkg::dataWidth-1:0]  cacheInst,
   input  wire [fetchPkg::dataWidth-1:0]  incPC,
   input  wire                            bubble,
   input  wire fetchPkg::stageInfo_t      stageEx,
   input  wire fetchPkg::stageInfo_t      stageMem,
   input  wire fetchPkg::stageInfo_t      stageWb,
   output fetchPkg::fetchOut_t            fetchOut,
   output fetchPkg::fwdCtrl_t             fwd,
   output logic                           loadUse,
   output logic                           fetchedHalt
);
   import fetchPkg::*;

   logic [dataWidth-1:0]    heldInst;
   logic [dataWidth-1:0]    heldIncPC;
   logic                    heldValid;
   opcode_t                 heldOp;
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rt;
   logic                    useRs;
   logic                    useRt;

   function automatic logic writes(stageInfo_t st, logic [regAddrWidth-1:0] r);
      return st.regWrt && (st.wrtReg == r);
   endfunction

   // youngest writer wins, a load in Ex cannot be forwarded yet
   function automatic fwdSel_t pickSource(logic [regAddrWidth-1:0] r);
      if (writes(stageEx, r)) begin
         return stageEx.isLoad ? fwdNone : fwdEx;
      end else if (writes(stageMem, r)) begin
         return fwdMem;
      end else if (writes(stageWb, r)) begin
         return fwdWb;
      end
      return fwdNone;
   endfunction

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         heldInst <= nopInst;
         heldIncPC <= '0;
         heldValid <= 1'b0;
      end else if (bubble) begin
         heldInst <= nopInst;
         heldValid <= 1'b0;
      end else if (!loadUse) begin
         // incPC of zero means pc rolled over the top of memory
         heldInst <= (incPC == '0) ? haltInst : cacheInst;
         heldIncPC <= incPC;
         heldValid <= 1'b1;
      end
   end

   assign heldOp = opcode_t'(heldInst[15:11]);
   assign rs = heldInst[10:8];
   assign rt = heldInst[7:5];
   assign useRs = readsRs(heldOp);
   assign useRt = readsRt(heldOp);

   assign loadUse = stageEx.isLoad &&
                    ((useRs && writes(stageEx, rs)) || (useRt && writes(stageEx, rt)));
   assign fetchedHalt = heldValid && (heldOp == opHalt);

   always_comb begin
      fwd.srcA = useRs ? pickSource(rs) : fwdNone;
      fwd.srcB = useRt ? pickSource(rt) : fwdNone;
      // decode sees a nop while the load result is outstanding
      fetchOut.instruction = loadUse ? nopInst : heldInst;
      fetchOut.incPC = heldIncPC;
      fetchOut.instrValid = heldValid && !loadUse;
   end

endmodule

`default_nettype wire

// ==== source/instCache.sv ====
// direct-mapped instruction cache with valid/tag store, data words and miss counter
`timescale 1ns/10ps
`default_nettype none

module instCache #(
   parameter int cacheLines  = 16,
   parameter int missLatency = 4
) (
   input  wire                            clk,
   input  wire                            rstN,
   input  wire [fetchPkg::dataWidth-1:0]  pc,
   input  wire                            cacheCancel,
   input  wire [fetchPkg::dataWidth-1:0]  memRdData,
   output logic                           hit,
   output logic [fetchPkg::dataWidth-1:0] cacheInst,
   output logic                           misaligned,
   output logic                           memRdEn,
   output logic [fetchPkg::dataWidth-2:0] memRdAddr
);
   import fetchPkg::*;

   localparam int indexBits = $clog2(cacheLines);
   localparam int tagBits = dataWidth - 1 - indexBits;
   localparam int cntBits = $clog2(missLatency + 1);

   logic [cacheLines-1:0] lineValid;
   logic [tagBits-1:0]    lineTag [cacheLines];
   logic [dataWidth-1:0]  lineData [cacheLines];

   logic [dataWidth-2:0] wordAddr;
   logic [indexBits-1:0] idx;
   logic [tagBits-1:0]   tag;
   logic                 lookupHit;
   logic                 pending;
   logic [cntBits-1:0]   fillCnt;
   logic                 fillDone;

   assign wordAddr = pc[dataWidth-1:1];
   assign idx = wordAddr[indexBits-1:0];
   assign tag = wordAddr[dataWidth-2:indexBits];

   assign misaligned = pc[0];
   assign lookupHit = lineValid[idx] && (lineTag[idx] == tag);

   // odd pc answers at once with a halt so the error can be reported
   assign hit = misaligned || lookupHit;
   assign cacheInst = misaligned ? haltInst : lineData[idx];

   // one memory read per miss, its data stays on memRdData
   assign memRdEn = !misaligned && !lookupHit && !pending && !cacheCancel;
   assign memRdAddr = wordAddr;

   assign fillDone = pending && (fillCnt == cntBits'(missLatency));

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         lineValid <= '0;
         pending <= 1'b0;
         fillCnt <= '0;
      end else if (cacheCancel) begin
         pending <= 1'b0;
      end else if (memRdEn) begin
         pending <= 1'b1;
         fillCnt <= cntBits'(1);
      end else if (fillDone) begin
         pending <= 1'b0;
         lineValid[idx] <= 1'b1;
      end else if (pending) begin
         fillCnt <= fillCnt + 1'b1;
      end
   end

   // pc is held during the fill, so idx and tag still name the missed line
   always_ff @(posedge clk) begin
      if (fillDone && !cacheCancel) begin
         lineTag[idx] <= tag;
         lineData[idx] <= memRdData;
      end
   end

endmodule

`default_nettype wire

// ==== source/instMem.sv ====
// word-addressed instruction memory, registered read port and program-load write port
`timescale 1ns/10ps
`default_nettype none

module instMem #(
   parameter int memWords = 256
) (
   input  wire                            clk,
   input  wire                            memRdEn,
   input  wire [fetchPkg::dataWidth-2:0]  memRdAddr,
   input  wire                            progWrEn,
   input  wire [fetchPkg::dataWidth-2:0]  progAddr,
   input  wire [fetchPkg::dataWidth-1:0]  progData,
   output logic [fetchPkg::dataWidth-1:0] memRdData
);
   import fetchPkg::*;

   localparam int addrBits = $clog2(memWords);

   logic [dataWidth-1:0] mem [memWords];
   logic [addrBits-1:0]  rdIdx;
   logic [addrBits-1:0]  wrIdx;

   // addresses beyond the array alias back into it
   assign rdIdx = addrBits'(memRdAddr % memWords);
   assign wrIdx = addrBits'(progAddr % memWords);

   always_ff @(posedge clk) begin
      if (progWrEn) begin
         mem[wrIdx] <= progData;
      end
      // read data is held until the next read
      if (memRdEn) begin
         memRdData <= mem[rdIdx];
      end
   end

endmodule

`default_nettype wire

// ==== source/pcGen.sv ====
// program counter register, +2 incrementer, redirect mux and wrap flag
`timescale 1ns/10ps
`default_nettype none

module pcGen (
   input  wire                            clk,
   input  wire                            rstN,
   input  wire                            pcWrEn,
   input  wire                            pcSel,
   input  wire [fetchPkg::dataWidth-1:0]  newPC,
   output logic [fetchPkg::dataWidth-1:0] pc,
   output logic [fetchPkg::dataWidth-1:0] incPC,
   output logic                           pcWrap
);
   import fetchPkg::*;

   // highest aligned address, incrementing past it rolls over to zero
   localparam logic [dataWidth-1:0] lastPC = {{(dataWidth-1){1'b1}}, 1'b0};

   logic [dataWidth-1:0] nextPC;

   assign incPC = pc + dataWidth'(2);
   assign pcWrap = (pc == lastPC);

   // jump target or branch fix-up when pcSel is set
   assign nextPC = pcSel ? newPC : incPC;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (pcWrEn) begin
         pc <= nextPC;
      end
   end

endmodule

`default_nettype wire

// ==== verification/fetchTb.sv ====
// fetch stage testbench with clock, program load, stimulus table and result checks
`timescale 1ns/10ps
`default_nettype none

module fetchTb;
   import fetchPkg::*;

   localparam int resetCycles = 10;
   localparam int timeoutCycles = 50;

   // one table row, the expected values belong to the next valid output
   typedef struct packed {
      logic                 rst;
      logic                 redirect;
      logic [dataWidth-1:0] newPC;
      logic                 dump;
      logic [3:0]           holdCycles;
      logic                 expectNone;
      stageInfo_t           ex;
      stageInfo_t           mem;
      stageInfo_t           wb;
      logic [dataWidth-1:0] expInst;
      logic [dataWidth-1:0] expIncPC;
      logic                 expErr;
      fwdCtrl_t             expFwd;
   } stepRow_t;

   logic                 clk;
   logic                 rstN;
   logic [dataWidth-1:0] newPC;
   logic                 redirect;
   logic                 createDump;
   stageInfo_t           stageEx;
   stageInfo_t           stageMem;
   stageInfo_t           stageWb;
   logic                 progWrEn;
   logic [dataWidth-2:0] progAddr;
   logic [dataWidth-1:0] progData;
   fetchOut_t            fetchOut;
   fwdCtrl_t             fwd;
   logic                 err;

   stepRow_t             steps [$];
   logic [dataWidth-1:0] progImage [resetCycles];
   integer               seed;
   int                   checks = 0;
   int                   errors = 0;

   fetch #(.cacheLines(16), .missLatency(4), .memWords(256)) u_dut (
      .clk(clk), .rstN(rstN), .newPC(newPC), .redirect(redirect), .createDump(createDump),
      .stageEx(stageEx), .stageMem(stageMem), .stageWb(stageWb),
      .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
      .fetchOut(fetchOut), .fwd(fwd), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [dataWidth-1:0] encode(opcode_t op, logic [2:0] rs, logic [2:0] rt);
      return {op, rs, rt, 5'b00000};
   endfunction

   // everything but halt and nop reads Rs
   function automatic logic usesSrcA(logic [dataWidth-1:0] inst);
      return !(inst[15:11] == opHalt || inst[15:11] == opNop);
   endfunction

   function automatic logic usesSrcB(logic [dataWidth-1:0] inst);
      case (inst[15:11])
         opSt, opAlu0, opAlu1, opAlu2, opAlu3: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Ex before Mem before Wb, a load still in Ex forwards nothing
   function automatic fwdSel_t expectSource(logic [2:0] r, stageInfo_t ex, stageInfo_t mem,
                                            stageInfo_t wb);
      if (ex.regWrt && ex.wrtReg == r) begin
         return ex.isLoad ? fwdNone : fwdEx;
      end
      if (mem.regWrt && mem.wrtReg == r) begin
         return fwdMem;
      end
      if (wb.regWrt && wb.wrtReg == r) begin
         return fwdWb;
      end
      return fwdNone;
   endfunction

   task automatic checkValue(input string what, input logic [15:0] actual,
                             input logic [15:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", what, actual, expected);
      end
   endtask

   task automatic addStep(input bit rst, input bit redir, input logic [15:0] target,
                          input bit dump, input int hold, input bit none,
                          input logic [15:0] inst, input logic [15:0] nextPC, input bit errExp);
      stepRow_t   s;
      stageInfo_t exSeen;
      logic [31:0] rnd;
      s = '0;
      s.rst = rst;
      s.redirect = redir;
      s.newPC = target;
      s.dump = dump;
      s.holdCycles = 4'(hold);
      s.expectNone = none;
      s.expInst = inst;
      s.expIncPC = nextPC;
      s.expErr = errExp;
      rnd = $random(seed);
      s.ex = rnd[4:0];
      s.ex.isLoad = 1'b0;
      rnd = $random(seed);
      s.mem = rnd[4:0];
      rnd = $random(seed);
      s.wb = rnd[4:0];
      // load in Ex that writes the Rs of this instruction
      if (hold != 0) begin
         s.ex = {1'b1, inst[10:8], 1'b1};
      end
      exSeen = (hold != 0) ? stageInfo_t'('0) : s.ex;
      s.expFwd.srcA = usesSrcA(inst) ? expectSource(inst[10:8], exSeen, s.mem, s.wb) : fwdNone;
      s.expFwd.srcB = usesSrcB(inst) ? expectSource(inst[7:5], exSeen, s.mem, s.wb) : fwdNone;
      steps.push_back(s);
   endtask

   task automatic buildTable();
      progImage[0] = encode(opAlu0, 3'd2, 3'd3);
      progImage[1] = encode(opImm0, 3'd4, 3'd0);
      progImage[2] = encode(opSt, 3'd5, 3'd6);
      progImage[3] = encode(opLd, 3'd1, 3'd7);
      progImage[4] = encode(opAlu2, 3'd7, 3'd0);
      progImage[5] = nopInst;
      progImage[6] = encode(opAlu3, 3'd3, 3'd3);
      progImage[7] = haltInst;
      progImage[8] = nopInst;
      progImage[9] = nopInst;
      // cold misses, then loop back to 0 for a second pass of hits
      addStep(1'b1, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[0], 16'd2, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[1], 16'd4, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[2], 16'd6, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[3], 16'd8, 1'b0);
      addStep(1'b0, 1'b1, 16'd0, 1'b0, 0, 1'b0, progImage[0], 16'd2, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[1], 16'd4, 1'b0);
      // redirect during a hit run drops the fetch of the strobe cycle
      addStep(1'b0, 1'b1, 16'd0, 1'b0, 0, 1'b0, progImage[0], 16'd2, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[1], 16'd4, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[2], 16'd6, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 8, 1'b0, progImage[3], 16'd8, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[4], 16'd10, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[5], 16'd12, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[6], 16'd14, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[7], 16'd16, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b1, 16'd0, 16'd0, 1'b0);
      // dump freezes the fetch
      addStep(1'b1, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[0], 16'd2, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[1], 16'd4, 1'b0);
      addStep(1'b0, 1'b0, 16'd0, 1'b1, 0, 1'b1, 16'd0, 16'd0, 1'b0);
      // jump to an odd address
      addStep(1'b1, 1'b0, 16'd0, 1'b0, 0, 1'b0, progImage[0], 16'd2, 1'b0);
      addStep(1'b0, 1'b1, 16'd5, 1'b0, 0, 1'b0, haltInst, 16'd7, 1'b1);
      addStep(1'b0, 1'b0, 16'd0, 1'b0, 0, 1'b1, 16'd0, 16'd0, 1'b1);
   endtask

   task automatic applyReset();
      int i;
      @(posedge clk);
      rstN <= 1'b0;
      redirect <= 1'b0;
      createDump <= 1'b0;
      stageEx <= '0;
      stageMem <= '0;
      stageWb <= '0;
      // program goes in while the fetch is held in reset
      for (i = 0; i < resetCycles; i++) begin
         progWrEn <= 1'b1;
         progAddr <= 15'(i);
         progData <= progImage[i];
         @(posedge clk);
      end
      progWrEn <= 1'b0;
      rstN <= 1'b1;
   endtask

   task automatic runStep(input stepRow_t s, input int idx);
      int n;
      bit seen;
      if (s.rst) begin
         applyReset();
      end
      @(posedge clk);
      redirect <= s.redirect;
      newPC <= s.newPC;
      createDump <= s.dump;
      stageEx <= s.ex;
      stageMem <= s.mem;
      stageWb <= s.wb;
      // single-cycle strobes, the output in the strobe cycle is not checked
      if (s.redirect || s.dump) begin
         @(posedge clk);
         redirect <= 1'b0;
         createDump <= 1'b0;
      end
      if (s.holdCycles != 0) begin
         for (n = 0; n < int'(s.holdCycles); n++) begin
            @(negedge clk);
            checkValue($sformatf("step %0d fetchOut.instrValid", idx),
                       16'(fetchOut.instrValid), 16'h0);
            checkValue($sformatf("step %0d fetchOut.instruction", idx),
                       fetchOut.instruction, nopInst);
         end
         @(posedge clk);
         stageEx <= '0;
      end
      if (s.expectNone) begin
         for (n = 0; n < timeoutCycles; n++) begin
            @(negedge clk);
            checkValue($sformatf("step %0d fetchOut.instrValid", idx),
                       16'(fetchOut.instrValid), 16'h0);
            checkValue($sformatf("step %0d err", idx), 16'(err), 16'(s.expErr));
         end
      end else begin
         seen = 1'b0;
         n = 0;
         while (!seen && n < timeoutCycles) begin
            @(negedge clk);
            seen = fetchOut.instrValid;
            n++;
         end
         if (!seen) begin
            errors++;
            $display("step %0d: no valid instruction appeared within %0d cycles",
                     idx, timeoutCycles);
         end else begin
            checkValue($sformatf("step %0d fetchOut.instruction", idx),
                       fetchOut.instruction, s.expInst);
            checkValue($sformatf("step %0d fetchOut.incPC", idx), fetchOut.incPC, s.expIncPC);
            checkValue($sformatf("step %0d fwd", idx), 16'(fwd), 16'(s.expFwd));
            checkValue($sformatf("step %0d err", idx), 16'(err), 16'(s.expErr));
         end
      end
   endtask

   initial begin
      rstN <= 1'b0;
      newPC <= '0;
      redirect <= 1'b0;
      createDump <= 1'b0;
      stageEx <= '0;
      stageMem <= '0;
      stageWb <= '0;
      progWrEn <= 1'b0;
      progAddr <= '0;
      progData <= '0;
      seed = 32'hafb5_bc18;
      buildTable();
      foreach (steps[i]) begin
         runStep(steps[i], i);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
